// ==== all.f ====
hw/fifo_pkg.sv
hw/nobl_pkg.sv
hw/word_splitter.sv
hw/word_assembler.sv
hw/nobl_ctrl.sv
hw/nobl_data_pipe.sv
hw/ext_fifo.sv
dv/nobl_sram_model.sv
dv/ext_fifo_tb.sv

// ==== dv/ext_fifo_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ext_fifo_tb
   import fifo_pkg::*;
   import nobl_pkg::*;
();

   localparam int RAM_DEPTH = 6;
   localparam int BUF_LOG2  = 2;
   localparam int N_ROWS    = 6;
   localparam int FILL_LO   = 2**RAM_DEPTH / 2;                  // SRAM alone in words
   localparam int FILL_HI   = FILL_LO + 2 * 2**BUF_LOG2 + 1;     // Plus both buffers

   logic                 ext_clk;
   logic                 rst_n;
   word_t                datain;
   logic                 src_rdy_in;
   logic                 dst_rdy_in;
   logic                 dst_rdy;
   logic                 src_rdy;
   word_t                dataout;
   sram_ctl_t            sram_ctl;
   logic [RAM_DEPTH-1:0] ram_a;
   half_t                ram_d_in;
   half_t                ram_d_out;
   logic                 ram_d_oe;
   int                   bus_errs;

   // Name, words, write %, read %, hold reads
   string tname   [N_ROWS] = '{"order", "fill", "drain",
                               "rand_even", "rand_slow_rd", "rand_slow_wr"};
   int    nwords  [N_ROWS] = '{12, 100, 0, 60, 80, 80};
   int    wr_pct  [N_ROWS] = '{100, 100, 0, 50, 90, 30};
   int    rd_pct  [N_ROWS] = '{100, 0, 100, 50, 20, 90};
   bit    hold_rd [N_ROWS] = '{0, 1, 0, 0, 0, 0};

   word_t expq [$];     // Scoreboard with oldest word first
   int    mism_cnt = 0;
   int    fail_cnt = 0;
   bit    abort    = 0;

   ext_fifo #(.RAM_DEPTH(RAM_DEPTH), .BUF_LOG2(BUF_LOG2)) u_dut (
      .ext_clk (ext_clk), .rst_n_i (rst_n),
      .datain_i (datain), .src_rdy_i (src_rdy_in), .dst_rdy_i (dst_rdy_in),
      .dst_rdy_o (dst_rdy), .src_rdy_o (src_rdy), .dataout_o (dataout),
      .sram_ctl_o (sram_ctl), .ram_a_o (ram_a),
      .ram_d_i (ram_d_in), .ram_d_o (ram_d_out), .ram_d_oe_o (ram_d_oe)
   );

   nobl_sram_model #(.ADDR_W(RAM_DEPTH)) u_sram (
      .ext_clk (ext_clk), .rst_n_i (rst_n), .ctl_i (sram_ctl), .addr_i (ram_a),
      .d_i (ram_d_out), .d_oe_i (ram_d_oe), .d_o (ram_d_in), .err_cnt_o (bus_errs)
   );

   initial begin
      ext_clk = 1'b0;
      forever #20 ext_clk = ~ext_clk;
   end

   task automatic check_word(input string name, input word_t exp, input word_t act);
      if (act !== exp) begin
         mism_cnt++;
         $display("Mismatch %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_flag(input string name, input bit exp, input logic act);
      if (act !== exp) begin
         mism_cnt++;
         $display("Mismatch %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic check_ctl(input string name, input sram_ctl_t exp, input sram_ctl_t act);
      if (act !== exp) begin
         mism_cnt++;
         $display("Mismatch %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   // One table row driven on rising edges and sampled on falling edges
   task automatic run_row(input int r);
      int sent;
      int low_run;
      int cycles;
      bit done;
      sent    = 0;
      low_run = 0;
      cycles  = 0;
      done    = 0;
      while (!done) begin
         @(posedge ext_clk);
         src_rdy_in <= (sent < nwords[r]) && ($urandom_range(99) < wr_pct[r]);
         datain     <= {4'($urandom()), $urandom()};
         dst_rdy_in <= !hold_rd[r] && ($urandom_range(99) < rd_pct[r]);
         @(negedge ext_clk);
         if (src_rdy_in && dst_rdy) begin
            expq.push_back(datain);   // Accepted on the coming edge
            sent++;
         end
         if (dst_rdy_in && src_rdy) begin
            if (expq.size() == 0) begin
               fail_cnt++;
               $display("%s: DUT returned a word that was never written", tname[r]);
            end else begin
               check_word(tname[r], expq.pop_front(), dataout);
            end
         end
         low_run = (src_rdy_in && !dst_rdy) ? low_run + 1 : 0;   // Full for good
         cycles++;
         if (hold_rd[r]) begin
            done = (low_run >= 16) || (sent == nwords[r]);
         end else begin
            done = (sent == nwords[r]) && (expq.size() == 0);
         end
         if (!done && cycles > 100 * nwords[r] + 2000) begin
            fail_cnt++;
            abort = 1'b1;
            done  = 1'b1;
            $display("%s: stalled, no progress after %0d cycles", tname[r], cycles);
         end
      end
      @(posedge ext_clk);
      src_rdy_in <= 1'b0;
      dst_rdy_in <= 1'b0;
      @(negedge ext_clk);
      if (hold_rd[r]) begin
         $display("%s: %0d words accepted before full", tname[r], sent);
         check_flag({tname[r], " fill level"}, 1'b1, (sent >= FILL_LO) && (sent <= FILL_HI));
      end else if (!abort) begin
         check_flag({tname[r], " empty after drain"}, 1'b0, src_rdy);
      end
   endtask

   initial begin
      void'($urandom(30));
      rst_n      = 1'b0;
      src_rdy_in = 1'b0;
      dst_rdy_in = 1'b0;
      datain     = '0;
      repeat (7) @(posedge ext_clk);
      @(negedge ext_clk);
      check_flag("reset src_rdy_o", 1'b0, src_rdy);
      check_flag("reset dst_rdy_o", 1'b1, dst_rdy);
      check_flag("reset ram_d_oe_o", 1'b0, ram_d_oe);
      check_ctl("reset sram_ctl_o", SRAM_CTL_IDLE, sram_ctl);
      @(posedge ext_clk);
      rst_n <= 1'b1;   // Released on the eighth rising edge
      for (int r = 0; r < N_ROWS && !abort; r++) begin
         run_row(r);
      end
      repeat (4) @(posedge ext_clk);
      $display("Errors: %0d mismatches, %0d other failures, %0d bus errors",
               mism_cnt, fail_cnt, bus_errs);
      if (mism_cnt == 0 && fail_cnt == 0 && bus_errs == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== dv/nobl_sram_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module nobl_sram_model
   import fifo_pkg::*;
   import nobl_pkg::*;
#(
   parameter int ADDR_W = 19   // SRAM address bits
) (
   input  wire              ext_clk,
   input  wire              rst_n_i,
   input  wire sram_ctl_t   ctl_i,
   input  wire [ADDR_W-1:0] addr_i,
   input  wire half_t       d_i,        // Bus as driven by the FIFO
   input  wire              d_oe_i,
   output half_t            d_o,        // Bus as driven by the SRAM
   output int               err_cnt_o
);

   // One loaded operation per pipeline stage
   typedef struct packed {
      logic              wr;
      logic              rd;
      logic [ADDR_W-1:0] addr;
   } op_t;

   half_t mem [2**ADDR_W];
   op_t   op_q [SRAM_LAT];
   op_t   op_now;
   logic  load;

   assign load        = !ctl_i.cen_n && !ctl_i.ld_n && !ctl_i.ce1_n;
   assign op_now.wr   = load && !ctl_i.we_n;
   assign op_now.rd   = load && ctl_i.we_n;
   assign op_now.addr = addr_i;

   // Read data only in the data phase, else floating
   assign d_o = op_q[SRAM_LAT-1].rd ? mem[op_q[SRAM_LAT-1].addr] : 'x;

   always_ff @(posedge ext_clk) begin
      if (!rst_n_i) begin
         for (int k = 0; k < SRAM_LAT; k++) begin
            op_q[k] <= '0;
         end
         err_cnt_o <= 0;
      end else begin
         op_q[0] <= op_now;
         for (int k = 1; k < SRAM_LAT; k++) begin
            op_q[k] <= op_q[k-1];
         end
         if (!ctl_i.we_n && ctl_i.ce1_n) begin
            $display("SRAM model: write strobe without chip enable at %0t", $time);
            err_cnt_o <= err_cnt_o + 1;
         end
         if (op_q[SRAM_LAT-1].rd && d_oe_i) begin
            $display("SRAM model: bus contention in a read data phase at %0t", $time);
            err_cnt_o <= err_cnt_o + 1;
         end else if (op_q[SRAM_LAT-1].wr && !d_oe_i) begin
            $display("SRAM model: write data phase with the bus undriven at %0t", $time);
            err_cnt_o <= err_cnt_o + 1;
         end else if (op_q[SRAM_LAT-1].wr) begin
            mem[op_q[SRAM_LAT-1].addr] <= d_i;   // Late write
         end
      end
   end

endmodule

`default_nettype wire

// ==== hw/ext_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module ext_fifo
   import fifo_pkg::*;
   import nobl_pkg::*;
#(
   parameter int RAM_DEPTH = 19,   // SRAM address bits
   parameter int BUF_LOG2  = 4     // On-chip buffers, log2 words
) (
   input  wire                  ext_clk,
   input  wire                  rst_n_i,
   input  wire word_t           datain_i,
   input  wire                  src_rdy_i,    // Write
   input  wire                  dst_rdy_i,    // Read
   output logic                 dst_rdy_o,    // Not full
   output logic                 src_rdy_o,    // Not empty
   output word_t                dataout_o,
   output sram_ctl_t            sram_ctl_o,
   output logic [RAM_DEPTH-1:0] ram_a_o,
   input  wire half_t           ram_d_i,
   output half_t                ram_d_o,
   output logic                 ram_d_oe_o
);

   buf_status_t split_status;
   half_t       split_half;
   logic        take;
   buf_status_t asm_status;
   ram_cmd_e    cmd;
   half_t       wr_half;
   half_t       rd_half;
   logic        rd_valid;

   // User words in, halves out
   word_splitter #(.BUF_LOG2(BUF_LOG2)) u_splitter (
      .ext_clk    (ext_clk),
      .rst_n_i    (rst_n_i),
      .wr_word_i  (datain_i),
      .wr_en_i    (src_rdy_i),
      .not_full_o (dst_rdy_o),
      .take_i     (take),
      .status_o   (split_status),
      .half_o     (split_half)
   );

   // Arbiter, pointers and address pins
   nobl_ctrl #(.RAM_DEPTH(RAM_DEPTH)) u_ctrl (
      .ext_clk        (ext_clk),
      .rst_n_i        (rst_n_i),
      .split_status_i (split_status),
      .split_half_i   (split_half),
      .take_o         (take),
      .asm_status_i   (asm_status),
      .cmd_o          (cmd),
      .wr_half_o      (wr_half),
      .sram_ctl_o     (sram_ctl_o),
      .ram_a_o        (ram_a_o)
   );

   // Data bus timing
   nobl_data_pipe u_data_pipe (
      .ext_clk    (ext_clk),
      .rst_n_i    (rst_n_i),
      .cmd_i      (cmd),
      .wr_half_i  (wr_half),
      .ram_d_i    (ram_d_i),
      .ram_d_o    (ram_d_o),
      .ram_d_oe_o (ram_d_oe_o),
      .rd_half_o  (rd_half),
      .rd_valid_o (rd_valid)
   );

   // Halves in, fall-through words out
   word_assembler #(.BUF_LOG2(BUF_LOG2)) u_assembler (
      .ext_clk      (ext_clk),
      .rst_n_i      (rst_n_i),
      .half_i       (rd_half),
      .half_valid_i (rd_valid),
      .rd_en_i      (dst_rdy_i),
      .word_o       (dataout_o),
      .not_empty_o  (src_rdy_o),
      .status_o     (asm_status)
   );

endmodule

`default_nettype wire

// ==== hw/fifo_pkg.sv ====
`default_nettype none

package fifo_pkg;

   // User word is two SRAM words wide
   localparam int WORD_W = 36;
   localparam int HALF_W = WORD_W / 2;

   typedef logic [WORD_W-1:0] word_t;   // One user word
   typedef logic [HALF_W-1:0] half_t;   // One SRAM word

   // Operation picked by the controller in a cycle
   typedef enum logic [1:0] {
      CMD_IDLE  = 2'b00,   // Nothing on the bus
      CMD_WRITE = 2'b01,   // Half from splitter into SRAM
      CMD_READ  = 2'b10    // Half from SRAM toward assembler
   } ram_cmd_e;

   // Buffer state as seen by the controller
   typedef struct packed {
      logic half_avail;   // Something ready to leave
      logic room;         // Space even for halves still in flight
   } buf_status_t;

   // Upper half goes to the SRAM first
   function automatic half_t upper_half(input word_t w);
      return w[WORD_W-1:HALF_W];
   endfunction

   function automatic half_t lower_half(input word_t w);
      return w[HALF_W-1:0];
   endfunction

   // Rebuild a user word, upper half first in time
   function automatic word_t join_halves(input half_t hi, input half_t lo);
      return {hi, lo};
   endfunction

endpackage

`default_nettype wire

// ==== hw/nobl_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module nobl_ctrl
   import fifo_pkg::*;
   import nobl_pkg::*;
#(
   parameter int RAM_DEPTH = 19   // SRAM address bits
) (
   input  wire                  ext_clk,
   input  wire                  rst_n_i,
   input  wire buf_status_t     split_status_i,
   input  wire half_t           split_half_i,
   output logic                 take_o,         // Splitter half consumed
   input  wire buf_status_t     asm_status_i,
   output ram_cmd_e             cmd_o,          // In step with the pins
   output half_t                wr_half_o,      // In step with the pins
   output sram_ctl_t            sram_ctl_o,
   output logic [RAM_DEPTH-1:0] ram_a_o
);

   logic [RAM_DEPTH-1:0] wr_ptr_q;    // Next SRAM word to write
   logic [RAM_DEPTH-1:0] rd_ptr_q;    // Next SRAM word to read
   logic [RAM_DEPTH:0]   occ_q;       // Halves stored, 0 .. 2^RAM_DEPTH
   logic                 rd_prio_q;   // Read wins the next tie
   logic                 can_wr;
   logic                 can_rd;
   ram_cmd_e             cmd_d;

   // MSB of occupancy set only when every location holds data
   assign can_wr = split_status_i.half_avail & ~occ_q[RAM_DEPTH];
   // Assembler room already covers reads in the pipe
   assign can_rd = (occ_q != '0) & asm_status_i.room;

   // One command per cycle, ties alternate
   always_comb begin
      cmd_d = CMD_IDLE;
      if (can_wr && can_rd) begin
         cmd_d = rd_prio_q ? CMD_READ : CMD_WRITE;
      end else if (can_wr) begin
         cmd_d = CMD_WRITE;
      end else if (can_rd) begin
         cmd_d = CMD_READ;
      end
   end

   assign take_o = (cmd_d == CMD_WRITE);   // Splitter steps on the same edge

   always_ff @(posedge ext_clk) begin
      if (!rst_n_i) begin
         sram_ctl_o <= SRAM_CTL_IDLE;
         ram_a_o    <= '0;
         cmd_o      <= CMD_IDLE;
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         occ_q      <= '0;
         rd_prio_q  <= 1'b0;
      end else begin
         cmd_o <= cmd_d;
         case (cmd_d)
            CMD_WRITE: begin
               sram_ctl_o <= SRAM_CTL_WRITE;
               ram_a_o    <= wr_ptr_q;
               wr_ptr_q   <= wr_ptr_q + 1'b1;   // Circular buffer
               occ_q      <= occ_q + 1'b1;
               rd_prio_q  <= 1'b1;              // Reads get the next tie
            end
            CMD_READ: begin
               sram_ctl_o <= SRAM_CTL_READ;
               ram_a_o    <= rd_ptr_q;
               rd_ptr_q   <= rd_ptr_q + 1'b1;
               occ_q      <= occ_q - 1'b1;
               rd_prio_q  <= 1'b0;              // Writes get the next tie
            end
            default: begin
               sram_ctl_o <= SRAM_CTL_IDLE;     // Address held
            end
         endcase
      end
   end

   // Write half rides along with its address
   always_ff @(posedge ext_clk) begin
      if (cmd_d == CMD_WRITE) begin
         wr_half_o <= split_half_i;
      end
   end

endmodule

`default_nettype wire

// ==== hw/nobl_data_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module nobl_data_pipe
   import fifo_pkg::*;
   import nobl_pkg::*;
(
   input  wire           ext_clk,
   input  wire           rst_n_i,
   input  wire ram_cmd_e cmd_i,        // Command as it leaves on the pins
   input  wire half_t    wr_half_i,
   input  wire half_t    ram_d_i,      // Data pins in
   output half_t         ram_d_o,      // Data pins out
   output logic          ram_d_oe_o,   // Drive the data pins
   output half_t         rd_half_o,
   output logic          rd_valid_o
);

   // Decoded command per stage
   typedef struct packed {
      logic wr;
      logic rd;
   } stage_t;

   stage_t stage_q [SRAM_LAT];
   half_t  data_q  [SRAM_LAT];

   // Last stage lines up with the SRAM data phase
   assign ram_d_o    = data_q[SRAM_LAT-1];
   assign ram_d_oe_o = stage_q[SRAM_LAT-1].wr;

   always_ff @(posedge ext_clk) begin
      if (!rst_n_i) begin
         for (int k = 0; k < SRAM_LAT; k++) begin
            stage_q[k] <= '0;
         end
         rd_valid_o <= 1'b0;
      end else begin
         stage_q[0].wr <= (cmd_i == CMD_WRITE);
         stage_q[0].rd <= (cmd_i == CMD_READ);
         for (int k = 1; k < SRAM_LAT; k++) begin
            stage_q[k] <= stage_q[k-1];    // Several commands in flight
         end
         rd_valid_o <= stage_q[SRAM_LAT-1].rd;   // One pulse per read
      end
   end

   // Write data shifts beside its command
   always_ff @(posedge ext_clk) begin
      data_q[0] <= wr_half_i;
      for (int k = 1; k < SRAM_LAT; k++) begin
         data_q[k] <= data_q[k-1];
      end
   end

   // Sample the bus in the read data phase
   always_ff @(posedge ext_clk) begin
      if (stage_q[SRAM_LAT-1].rd) begin
         rd_half_o <= ram_d_i;
      end
   end

endmodule

`default_nettype wire

// ==== hw/nobl_pkg.sv ====
`default_nettype none

package nobl_pkg;

   // Data follows address by this many clocks, reads and writes alike
   localparam int SRAM_LAT = 2;

   // Active-low control pins of the NoBL part
   typedef struct packed {
      logic we_n;    // Write enable
      logic cen_n;   // Clock enable
      logic ld_n;    // Address load
      logic oe_n;    // Output enable
      logic ce1_n;   // Chip enable
   } sram_ctl_t;

   // Everything released
   localparam sram_ctl_t SRAM_CTL_IDLE = '{
      we_n: 1'b1, cen_n: 1'b1, ld_n: 1'b1, oe_n: 1'b1, ce1_n: 1'b1
   };

   // Load a write address, SRAM keeps its outputs off
   localparam sram_ctl_t SRAM_CTL_WRITE = '{
      we_n: 1'b0, cen_n: 1'b0, ld_n: 1'b0, oe_n: 1'b1, ce1_n: 1'b0
   };

   // Load a read address, data comes back SRAM_LAT later
   localparam sram_ctl_t SRAM_CTL_READ = '{
      we_n: 1'b1, cen_n: 1'b0, ld_n: 1'b0, oe_n: 1'b0, ce1_n: 1'b0
   };

endpackage

`default_nettype wire

// ==== hw/word_assembler.sv ====
`timescale 1ns/1ps
`default_nettype none

module word_assembler
   import fifo_pkg::*;
   import nobl_pkg::*;
#(
   parameter int BUF_LOG2 = 4   // log2 of depth in user words
) (
   input  wire         ext_clk,
   input  wire         rst_n_i,
   input  wire half_t  half_i,        // Half back from the SRAM
   input  wire         half_valid_i,
   input  wire         rd_en_i,       // Read strobe
   output word_t       word_o,        // Fall-through head word
   output logic        not_empty_o,
   output buf_status_t status_o
);

   localparam int unsigned DEPTH      = 2 ** BUF_LOG2;
   localparam int unsigned CAP_HALVES = 2 * DEPTH;
   // Reads issued but not yet landed here
   // Controller register, SRAM pipe, capture register
   localparam int unsigned IN_FLIGHT  = SRAM_LAT + 2;

   word_t               mem_q [DEPTH];
   half_t               hi_q;            // Upper half waiting for its partner
   logic [BUF_LOG2-1:0] wr_ptr_q;
   logic [BUF_LOG2-1:0] rd_ptr_q;
   logic [BUF_LOG2:0]   count_q;         // Whole words held
   logic                lo_next_q;       // Next half in is a lower half
   logic                push;
   logic                pop;
   logic [BUF_LOG2+1:0] used_halves;
   logic [BUF_LOG2+1:0] free_halves;

   assign push = half_valid_i & lo_next_q;   // Word complete
   assign pop  = rd_en_i & not_empty_o;      // Reads while empty are dropped

   assign not_empty_o = (count_q != '0);
   assign word_o      = mem_q[rd_ptr_q];     // No register on the way out

   // Two halves per word plus a pending upper half
   assign used_halves = {count_q, lo_next_q};
   assign free_halves = (BUF_LOG2+2)'(CAP_HALVES) - used_halves;

   assign status_o.half_avail = not_empty_o;
   assign status_o.room       = (free_halves > (BUF_LOG2+2)'(IN_FLIGHT + 1));

   // Upper half parks here until the lower one shows up
   always_ff @(posedge ext_clk) begin
      if (half_valid_i && !lo_next_q) begin
         hi_q <= half_i;
      end
   end

   always_ff @(posedge ext_clk) begin
      if (push) begin
         mem_q[wr_ptr_q] <= join_halves(hi_q, half_i);
      end
   end

   always_ff @(posedge ext_clk) begin
      if (!rst_n_i) begin
         wr_ptr_q  <= '0;
         rd_ptr_q  <= '0;
         count_q   <= '0;
         lo_next_q <= 1'b0;
      end else begin
         if (half_valid_i) begin
            lo_next_q <= ~lo_next_q;
         end
         if (push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({push, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== hw/word_splitter.sv ====
`timescale 1ns/1ps
`default_nettype none

module word_splitter
   import fifo_pkg::*;
#(
   parameter int BUF_LOG2 = 4   // log2 of depth in user words
) (
   input  wire         ext_clk,
   input  wire         rst_n_i,
   input  wire word_t  wr_word_i,    // User word in
   input  wire         wr_en_i,      // Write strobe
   output logic        not_full_o,
   input  wire         take_i,       // Controller consumed half_o
   output buf_status_t status_o,
   output half_t       half_o        // Half offered to the SRAM side
);

   localparam int unsigned DEPTH = 2 ** BUF_LOG2;

   word_t               mem_q [DEPTH];   // Word storage
   logic [BUF_LOG2-1:0] wr_ptr_q;
   logic [BUF_LOG2-1:0] rd_ptr_q;
   logic [BUF_LOG2:0]   count_q;         // Whole words held
   logic                lo_sel_q;        // Lower half of head word is next
   logic                push;
   logic                pop;
   word_t               head;

   assign not_full_o = (count_q != (BUF_LOG2+1)'(DEPTH));
   assign push       = wr_en_i & not_full_o;   // Writes while full are dropped
   assign pop        = take_i & lo_sel_q;      // Word retires with its lower half

   // Head word, upper half first
   assign head   = mem_q[rd_ptr_q];
   assign half_o = lo_sel_q ? lower_half(head) : upper_half(head);

   assign status_o.half_avail = (count_q != '0);
   assign status_o.room       = not_full_o;

   // Storage
   always_ff @(posedge ext_clk) begin
      if (push) begin
         mem_q[wr_ptr_q] <= wr_word_i;
      end
   end

   always_ff @(posedge ext_clk) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
         lo_sel_q <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;   // Wraps at DEPTH
         end
         if (take_i) begin
            lo_sel_q <= ~lo_sel_q;          // Upper, lower, upper ...
         end
         if (pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({push, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;    // Both or neither
         endcase
      end
   end

endmodule

`default_nettype wire
